//--- files.f
+incdir+logic
logic/gat_pkg.sv
logic/gat_memory.sv
logic/row_scheduler.sv
logic/feature_mac.sv
logic/gat_top.sv
bench/gat_assert.sv
bench/gat_tb.sv

//--- bench/gat_tb.sv
// Two random loads with fixed seed; H rows packed in node order and node 3 always left empty
`timescale 1ns/1ns
`include "gat_defs.svh"

module gat_tb;
  import gat_pkg::*;

  localparam int IN        = `GAT_NUM_FEATURE_IN;
  localparam int OUT       = `GAT_NUM_FEATURE_OUT;
  localparam int NODES     = `GAT_TOTAL_NODES;
  localparam int MAX_CYCLE = 2 * (16 + 8 * (4 + 2) + 200);

  logic                        clk;
  logic                        rst_n;
  h_entry_t                    h_data_bram_din;
  logic                        h_data_bram_ena;
  logic                        h_data_bram_wea;
  logic [`GAT_H_ADDR_W-1:0]    h_data_bram_addra;
  logic [`GAT_ROW_LEN_W-1:0]   h_node_info_bram_din;
  logic                        h_node_info_bram_ena;
  logic                        h_node_info_bram_wea;
  logic [`GAT_NODE_W-1:0]      h_node_info_bram_addra;
  logic [`GAT_DATA_WIDTH-1:0]  wgt_bram_din;
  logic                        wgt_bram_ena;
  logic                        wgt_bram_wea;
  logic [`GAT_WGT_ADDR_W-1:0]  wgt_bram_addra;
  logic                        h_data_bram_load_done;
  logic                        h_node_info_bram_load_done;
  logic                        wgt_bram_load_done;
  logic [`GAT_FEAT_ADDR_W-1:0] feat_bram_addrb;
  logic [`GAT_FEAT_WIDTH-1:0]  feat_bram_dout;
  logic                        gat_ready;

  // Reference copies of the loaded data
  logic signed [7:0] w_ref [IN][OUT];
  logic signed [7:0] h_val [`GAT_H_DEPTH];
  int                h_col [`GAT_H_DEPTH];
  int                h_base [NODES];
  int                row_len_ref [NODES];
  integer            seed;
  int                cycle_cnt;

  gat_top i_gat_top (.*);

  bind gat_top gat_assert u_gat_assert (
    .clk                        (clk),
    .rst_n                      (rst_n),
    .h_data_bram_load_done      (h_data_bram_load_done),
    .h_node_info_bram_load_done (h_node_info_bram_load_done),
    .wgt_bram_load_done         (wgt_bram_load_done),
    .gat_ready                  (gat_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // Timeout and bound assertion watch
  always @(negedge clk) begin
    cycle_cnt++;
    if (i_gat_top.u_gat_assert.fail_count != 0) begin
      abort_run("A bound assertion on gat_ready failed");
    end else if (cycle_cnt > MAX_CYCLE) begin
      abort_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  // ==============================
  // Host loading
  // ==============================
  task automatic load_memories();
    int addr;
    int col;
    int rnd;
    logic [IN-1:0] used;
    @(posedge clk);
    h_data_bram_load_done      <= 1'b0;
    h_node_info_bram_load_done <= 1'b0;
    wgt_bram_load_done         <= 1'b0;
    for (int r = 0; r < IN; r++) begin
      for (int o = 0; o < OUT; o++) begin
        rnd = $random(seed);
        w_ref[r][o] = rnd[7:0];
        @(posedge clk);
        wgt_bram_ena   <= 1'b1;
        wgt_bram_wea   <= 1'b1;
        wgt_bram_addra <= (`GAT_WGT_ADDR_W)'(r * OUT + o);
        wgt_bram_din   <= rnd[7:0];
      end
    end
    for (int n = 0; n < NODES; n++) begin
      rnd = $random(seed);
      row_len_ref[n] = (n == 3) ? 0 : (rnd & 32'h7fff_ffff) % 5;
      @(posedge clk);
      wgt_bram_ena           <= 1'b0;
      wgt_bram_wea           <= 1'b0;
      h_node_info_bram_ena   <= 1'b1;
      h_node_info_bram_wea   <= 1'b1;
      h_node_info_bram_addra <= (`GAT_NODE_W)'(n);
      h_node_info_bram_din   <= (`GAT_ROW_LEN_W)'(row_len_ref[n]);
    end
    @(posedge clk);
    h_node_info_bram_ena <= 1'b0;
    h_node_info_bram_wea <= 1'b0;
    addr = 0;
    for (int n = 0; n < NODES; n++) begin
      h_base[n] = addr;
      used = '0;
      for (int j = 0; j < row_len_ref[n]; j++) begin
        // Redraw until the column is new in this row
        do begin
          rnd = $random(seed);
          col = (rnd & 32'h7fff_ffff) % IN;
        end while (used[col]);
        used[col] = 1'b1;
        rnd = $random(seed);
        h_val[addr] = rnd[7:0];
        h_col[addr] = col;
        @(posedge clk);
        h_data_bram_ena   <= 1'b1;
        h_data_bram_wea   <= 1'b1;
        h_data_bram_addra <= (`GAT_H_ADDR_W)'(addr);
        h_data_bram_din   <= '{value: rnd[7:0], col: col[`GAT_COL_W-1:0]};
        addr++;
      end
    end
    @(posedge clk);
    h_data_bram_ena <= 1'b0;
    h_data_bram_wea <= 1'b0;
  endtask

  function automatic int expected_feature(input int n, input int o);
    int sum;
    int a;
    sum = 0;
    for (int j = 0; j < row_len_ref[n]; j++) begin
      a = h_base[n] + j;
      sum += h_val[a] * w_ref[h_col[a]][o];
    end
    return sum;
  endfunction

  // ==============================
  // Start, ready timing, read-back
  // ==============================
  task automatic run_and_check();
    int cycles;
    int expected_cycles;
    int exp_val;
    expected_cycles = 1;
    for (int n = 0; n < NODES; n++) begin
      expected_cycles += row_len_ref[n] + 2;
    end
    @(posedge clk);
    h_data_bram_load_done      <= 1'b1;
    h_node_info_bram_load_done <= 1'b1;
    wgt_bram_load_done         <= 1'b1;
    cycles = 0;
    @(negedge clk);
    while (!gat_ready) begin
      cycles++;
      @(negedge clk);
    end
    assert (cycles == expected_cycles)
      else abort_run($sformatf("FAIL at %0t: gat_ready after %0d cycles, expected %0d",
                               $time, cycles, expected_cycles));
    for (int a = 0; a < NODES * OUT; a++) begin
      @(posedge clk);
      feat_bram_addrb <= (`GAT_FEAT_ADDR_W)'(a);
      @(negedge clk);
      exp_val = expected_feature(a / OUT, a % OUT);
      if (row_len_ref[a / OUT] == 0) begin
        assert (feat_bram_dout == '0)
          else abort_run($sformatf("FAIL at %0t: empty node feature address %0d not zero",
                                   $time, a));
      end else begin
        assert (feat_bram_dout == exp_val)
          else abort_run($sformatf("FAIL at %0t: feature address %0d read %0d, expected %0d",
                                   $time, a, $signed(feat_bram_dout), exp_val));
      end
    end
  endtask

  initial begin
    seed                       = 95;
    cycle_cnt                  = 0;
    h_data_bram_din            = '0;
    h_data_bram_ena            = 1'b0;
    h_data_bram_wea            = 1'b0;
    h_data_bram_addra          = '0;
    h_node_info_bram_din       = '0;
    h_node_info_bram_ena       = 1'b0;
    h_node_info_bram_wea       = 1'b0;
    h_node_info_bram_addra     = '0;
    wgt_bram_din               = '0;
    wgt_bram_ena               = 1'b0;
    wgt_bram_wea               = 1'b0;
    wgt_bram_addra             = '0;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    feat_bram_addrb            = '0;
    // Clean falling edge for the async reset
    rst_n = 1'b1;
    #1 rst_n = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    load_memories();
    run_and_check();
    // Drop one level, then reload and compute again
    @(posedge clk);
    wgt_bram_load_done <= 1'b0;
    repeat (2) @(posedge clk);
    load_memories();
    run_and_check();
    @(negedge clk);
    if (i_gat_top.u_gat_assert.fail_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      abort_run("A bound assertion on gat_ready failed");
    end
  end

endmodule

//--- bench/gat_assert.sv
// Watches only the top-level ready level against reset and the three load-done levels
`timescale 1ns/1ns

module gat_assert (
  input logic clk,
  input logic rst_n,
  input logic h_data_bram_load_done,
  input logic h_node_info_bram_load_done,
  input logic wgt_bram_load_done,
  input logic gat_ready
);

  logic        all_loaded;
  int unsigned fail_count = 0;

  assign all_loaded = h_data_bram_load_done & h_node_info_bram_load_done & wgt_bram_load_done;

  // ==============================
  // Ready level
  // ==============================
  ready_low_in_reset: assert property (@(posedge clk) !rst_n |-> !gat_ready)
    else begin
      fail_count++;
      $error("gat_ready high while reset is held");
    end

  // No ready unless every load was done at the previous edge
  ready_needs_load: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(all_loaded) |-> !gat_ready)
    else begin
      fail_count++;
      $error("gat_ready high without all load-done levels");
    end

  ready_falls_on_drop: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(all_loaded) |=> !gat_ready)
    else begin
      fail_count++;
      $error("gat_ready still high a cycle after a load-done level fell");
    end

  ready_holds: assert property (@(posedge clk) disable iff (!rst_n)
    gat_ready && all_loaded |=> gat_ready)
    else begin
      fail_count++;
      $error("gat_ready dropped while all loads stayed done");
    end

endmodule

//--- logic/gat_top.sv
// Host must finish all three loads before raising the load-done levels and not write while busy
`timescale 1ns/1ns
`include "gat_defs.svh"

module gat_top (
  input  logic                         clk,
  input  logic                         rst_n,

  input  gat_pkg::h_entry_t            h_data_bram_din,
  input  logic                         h_data_bram_ena,
  input  logic                         h_data_bram_wea,
  input  logic [`GAT_H_ADDR_W-1:0]     h_data_bram_addra,

  input  logic [`GAT_ROW_LEN_W-1:0]    h_node_info_bram_din,
  input  logic                         h_node_info_bram_ena,
  input  logic                         h_node_info_bram_wea,
  input  logic [`GAT_NODE_W-1:0]       h_node_info_bram_addra,

  input  logic [`GAT_DATA_WIDTH-1:0]   wgt_bram_din,
  input  logic                         wgt_bram_ena,
  input  logic                         wgt_bram_wea,
  input  logic [`GAT_WGT_ADDR_W-1:0]   wgt_bram_addra,

  input  logic                         h_data_bram_load_done,
  input  logic                         h_node_info_bram_load_done,
  input  logic                         wgt_bram_load_done,

  input  logic [`GAT_FEAT_ADDR_W-1:0]  feat_bram_addrb,
  output logic [`GAT_FEAT_WIDTH-1:0]   feat_bram_dout,
  output logic                         gat_ready
);
  import gat_pkg::*;

  logic [`GAT_NODE_W-1:0]    node_idx;
  logic [`GAT_H_ADDR_W-1:0]  h_addr;
  logic [`GAT_ROW_LEN_W-1:0] row_len;
  h_entry_t                  h_entry;
  wgt_row_t                  wgt_row;
  feat_row_t                 feat_row;
  logic                      acc_clear;
  logic                      acc_en;
  logic                      feat_we;

  // ==============================
  // Storage
  // ==============================
  gat_memory u_gat_memory (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .h_data_bram_din        (h_data_bram_din),
    .h_data_bram_ena        (h_data_bram_ena),
    .h_data_bram_wea        (h_data_bram_wea),
    .h_data_bram_addra      (h_data_bram_addra),
    .h_node_info_bram_din   (h_node_info_bram_din),
    .h_node_info_bram_ena   (h_node_info_bram_ena),
    .h_node_info_bram_wea   (h_node_info_bram_wea),
    .h_node_info_bram_addra (h_node_info_bram_addra),
    .wgt_bram_din           (wgt_bram_din),
    .wgt_bram_ena           (wgt_bram_ena),
    .wgt_bram_wea           (wgt_bram_wea),
    .wgt_bram_addra         (wgt_bram_addra),
    .node_idx               (node_idx),
    .h_addr                 (h_addr),
    .row_len                (row_len),
    .h_entry                (h_entry),
    .wgt_row                (wgt_row),
    .feat_we                (feat_we),
    .feat_row               (feat_row),
    .feat_bram_addrb        (feat_bram_addrb),
    .feat_bram_dout         (feat_bram_dout)
  );

  // ==============================
  // Sequencer and datapath
  // ==============================
  row_scheduler u_row_scheduler (
    .clk                        (clk),
    .rst_n                      (rst_n),
    .h_data_bram_load_done      (h_data_bram_load_done),
    .h_node_info_bram_load_done (h_node_info_bram_load_done),
    .wgt_bram_load_done         (wgt_bram_load_done),
    .row_len                    (row_len),
    .node_idx                   (node_idx),
    .h_addr                     (h_addr),
    .acc_clear                  (acc_clear),
    .acc_en                     (acc_en),
    .feat_we                    (feat_we),
    .gat_ready                  (gat_ready)
  );

  feature_mac u_feature_mac (
    .clk       (clk),
    .rst_n     (rst_n),
    .acc_clear (acc_clear),
    .acc_en    (acc_en),
    .h_entry   (h_entry),
    .wgt_row   (wgt_row),
    .feat_row  (feat_row)
  );

endmodule

//--- logic/feature_mac.sv
// Accumulators do not saturate; sums must fit GAT_FEAT_WIDTH for the loaded data
`timescale 1ns/1ns
`include "gat_defs.svh"

module feature_mac (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                acc_clear,
  input  logic                acc_en,

  input  gat_pkg::h_entry_t   h_entry,
  input  gat_pkg::wgt_row_t   wgt_row,

  output gat_pkg::feat_row_t  feat_row
);
  import gat_pkg::*;

  feat_row_t                        acc_q;
  logic signed [`GAT_FEAT_WIDTH-1:0] prod [`GAT_NUM_FEATURE_OUT];

  // ==============================
  // Products
  // ==============================

  // Sign-extended to the accumulator width
  always_comb begin
    for (int i = 0; i < `GAT_NUM_FEATURE_OUT; i++) begin
      prod[i] = h_entry.value * $signed(wgt_row.w[i]);
    end
  end

  // ==============================
  // Accumulators
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (acc_clear) begin
      acc_q <= '0;
    end else if (acc_en) begin
      for (int i = 0; i < `GAT_NUM_FEATURE_OUT; i++) begin
        acc_q.feat[i] <= acc_q.feat[i] + prod[i];
      end
    end
  end

  assign feat_row = acc_q;

endmodule

//--- logic/row_scheduler.sv
// One node in flight; H entries of all nodes must be packed back to back in node order
`timescale 1ns/1ns
`include "gat_defs.svh"

module row_scheduler (
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         h_data_bram_load_done,
  input  logic                         h_node_info_bram_load_done,
  input  logic                         wgt_bram_load_done,

  input  logic [`GAT_ROW_LEN_W-1:0]    row_len,
  output logic [`GAT_NODE_W-1:0]       node_idx,
  output logic [`GAT_H_ADDR_W-1:0]     h_addr,

  output logic                         acc_clear,
  output logic                         acc_en,
  output logic                         feat_we,
  output logic                         gat_ready
);
  import gat_pkg::*;

  sched_state_t              state;
  sched_state_t              next_state;
  logic [`GAT_ROW_LEN_W-1:0] entry_cnt;
  logic                      all_loaded;
  logic                      last_entry;
  logic                      last_node;

  assign all_loaded = h_data_bram_load_done & h_node_info_bram_load_done & wgt_bram_load_done;
  assign last_entry = (entry_cnt == row_len - 1'b1);
  assign last_node  = (node_idx == (`GAT_TOTAL_NODES - 1));

  // ==============================
  // Next state
  // ==============================
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (all_loaded) begin
          next_state = ROW;
        end
      end
      // Empty row skips straight to the write
      ROW: begin
        next_state = (row_len == '0) ? WRITE : ENTRY;
      end
      ENTRY: begin
        if (last_entry) begin
          next_state = WRITE;
        end
      end
      WRITE: begin
        next_state = last_node ? DONE : ROW;
      end
      DONE: begin
        next_state = DONE;
      end
      default: begin
        next_state = IDLE;
      end
    endcase
    // Dropping any load-done level aborts or releases the core
    if (!all_loaded) begin
      next_state = IDLE;
    end
  end

  // ==============================
  // State and counters
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      node_idx  <= '0;
      h_addr    <= '0;
      entry_cnt <= '0;
    end else begin
      state <= next_state;
      case (state)
        IDLE: begin
          node_idx <= '0;
          h_addr   <= '0;
        end
        ROW: begin
          entry_cnt <= '0;
        end
        // Running H address carries into the next node
        ENTRY: begin
          h_addr    <= h_addr + 1'b1;
          entry_cnt <= entry_cnt + 1'b1;
        end
        WRITE: begin
          if (!last_node) begin
            node_idx <= node_idx + 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Strobes decoded from the current state
  assign acc_clear = (state == ROW);
  assign acc_en    = (state == ENTRY);
  assign feat_we   = (state == WRITE);
  assign gat_ready = (state == DONE);

endmodule

//--- logic/gat_memory.sv
// All reads are combinational; weight and feature addresses past the stored range are ignored
`timescale 1ns/1ns
`include "gat_defs.svh"

module gat_memory (
  input  logic                         clk,
  input  logic                         rst_n,

  input  gat_pkg::h_entry_t            h_data_bram_din,
  input  logic                         h_data_bram_ena,
  input  logic                         h_data_bram_wea,
  input  logic [`GAT_H_ADDR_W-1:0]     h_data_bram_addra,

  input  logic [`GAT_ROW_LEN_W-1:0]    h_node_info_bram_din,
  input  logic                         h_node_info_bram_ena,
  input  logic                         h_node_info_bram_wea,
  input  logic [`GAT_NODE_W-1:0]       h_node_info_bram_addra,

  input  logic [`GAT_DATA_WIDTH-1:0]   wgt_bram_din,
  input  logic                         wgt_bram_ena,
  input  logic                         wgt_bram_wea,
  input  logic [`GAT_WGT_ADDR_W-1:0]   wgt_bram_addra,

  input  logic [`GAT_NODE_W-1:0]       node_idx,
  input  logic [`GAT_H_ADDR_W-1:0]     h_addr,
  output logic [`GAT_ROW_LEN_W-1:0]    row_len,
  output gat_pkg::h_entry_t            h_entry,
  output gat_pkg::wgt_row_t            wgt_row,

  input  logic                         feat_we,
  input  gat_pkg::feat_row_t           feat_row,

  input  logic [`GAT_FEAT_ADDR_W-1:0]  feat_bram_addrb,
  output logic [`GAT_FEAT_WIDTH-1:0]   feat_bram_dout
);
  import gat_pkg::*;

  h_entry_t                  h_mem    [`GAT_H_DEPTH];
  logic [`GAT_ROW_LEN_W-1:0] info_mem [`GAT_TOTAL_NODES];
  wgt_row_t                  wgt_mem  [`GAT_NUM_FEATURE_IN];
  feat_row_t                 feat_mem [`GAT_TOTAL_NODES];

  // ==============================
  // Host loading
  // ==============================
  always_ff @(posedge clk) begin
    if (h_data_bram_ena && h_data_bram_wea) begin
      h_mem[h_data_bram_addra] <= h_data_bram_din;
    end
  end

  // Unloaded nodes read as empty rows
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `GAT_TOTAL_NODES; i++) begin
        info_mem[i] <= '0;
      end
    end else if (h_node_info_bram_ena && h_node_info_bram_wea) begin
      info_mem[h_node_info_bram_addra] <= h_node_info_bram_din;
    end
  end

  // Flat weight address split into W row and column
  always_ff @(posedge clk) begin
    if (wgt_bram_ena && wgt_bram_wea) begin
      wgt_mem[wgt_bram_addra / `GAT_NUM_FEATURE_OUT].w[wgt_bram_addra % `GAT_NUM_FEATURE_OUT]
        <= wgt_bram_din;
    end
  end

  // ==============================
  // Core side
  // ==============================
  assign row_len = info_mem[node_idx];
  assign h_entry = h_mem[h_addr];
  // W row picked by the current entry's column
  assign wgt_row = wgt_mem[h_entry.col];

  always_ff @(posedge clk) begin
    if (feat_we) begin
      feat_mem[node_idx] <= feat_row;
    end
  end

  // Host read of one feature word
  assign feat_bram_dout =
    feat_mem[feat_bram_addrb / `GAT_NUM_FEATURE_OUT].feat[feat_bram_addrb % `GAT_NUM_FEATURE_OUT];

endmodule

//--- logic/gat_pkg.sv
// Types for the first-layer transform only; sizes come from gat_defs.svh and are not parameters
`include "gat_defs.svh"

package gat_pkg;

  // ==============================
  // Sparse H entry
  // ==============================
  typedef struct packed {
    logic signed [`GAT_DATA_WIDTH-1:0] value;
    logic        [`GAT_COL_W-1:0]      col;
  } h_entry_t;

  // ==============================
  // Dense rows
  // ==============================

  // One W row, element i feeds output feature i
  typedef struct packed {
    logic [`GAT_NUM_FEATURE_OUT-1:0][`GAT_DATA_WIDTH-1:0] w;
  } wgt_row_t;

  // New features of one node, two's complement
  typedef struct packed {
    logic [`GAT_NUM_FEATURE_OUT-1:0][`GAT_FEAT_WIDTH-1:0] feat;
  } feat_row_t;

  // ==============================
  // Scheduler
  // ==============================
  typedef enum logic [2:0] {
    IDLE,
    ROW,
    ENTRY,
    WRITE,
    DONE
  } sched_state_t;

endpackage

//--- logic/gat_defs.svh
// Sizes are fixed for one small graph; widths derive from them and every count must be at least 2
`ifndef GAT_DEFS_SVH
`define GAT_DEFS_SVH

// ==============================
// Graph and feature sizes
// ==============================
`define GAT_TOTAL_NODES      8
`define GAT_NUM_FEATURE_IN   11
`define GAT_NUM_FEATURE_OUT  4
`define GAT_H_DEPTH          64

// ==============================
// Data widths
// ==============================
`define GAT_DATA_WIDTH       8
`define GAT_FEAT_WIDTH       32

// ==============================
// Derived address and index widths
// ==============================
`define GAT_COL_W        ($clog2(`GAT_NUM_FEATURE_IN))
`define GAT_NODE_W       ($clog2(`GAT_TOTAL_NODES))
`define GAT_H_ADDR_W     ($clog2(`GAT_H_DEPTH))
// A row may hold every input column
`define GAT_ROW_LEN_W    ($clog2(`GAT_NUM_FEATURE_IN + 1))
// Weight word at row * GAT_NUM_FEATURE_OUT + column
`define GAT_WGT_ADDR_W   ($clog2(`GAT_NUM_FEATURE_IN * `GAT_NUM_FEATURE_OUT))
// Feature word at node * GAT_NUM_FEATURE_OUT + output index
`define GAT_FEAT_ADDR_W  ($clog2(`GAT_TOTAL_NODES * `GAT_NUM_FEATURE_OUT))

`endif
